// File: hdl/crossbar_pkg.sv
package crossbar_pkg;

	//////////////////////////////////////////////////////////////////////
	// Trigger lines

	//Front panel trigger count, inputs and outputs alike
	localparam int N_TRIG = 12;

	//One bit per trigger line
	typedef logic [N_TRIG-1:0] trig_vec_t;

	//Per-output selector, index of the input it follows
	typedef logic [3:0] muxsel_t;

	//Output forced low
	//Any value of N_TRIG or above does the same
	localparam muxsel_t MUXSEL_OFF = 4'd15;

	//////////////////////////////////////////////////////////////////////
	// Latching relays

	//Relays on the H-bridge driver
	localparam int N_RELAY = 4;

	//One bit per relay coil side
	typedef logic [N_RELAY-1:0] relay_vec_t;

	//Relay number
	typedef logic [$clog2(N_RELAY)-1:0] relay_chan_t;

endpackage

// File: hdl/axil_regmap_pkg.sv
package axil_regmap_pkg;

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite bus widths

	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [AXI_STRB_W-1:0] axi_strb_t;
	typedef logic [1:0]            axi_resp_t;

	//Response codes
	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	//////////////////////////////////////////////////////////////////////
	// Register map, byte addresses

	//Output k selector at base + 4*k, bits 3:0
	localparam axi_addr_t REG_MUXSEL_BASE = 8'h00;

	//Relay move, bits 1:0 channel, bit 4 side A when set
	localparam axi_addr_t REG_RELAY_CMD   = 8'h40;
	localparam int        RELAY_DIR_BIT   = 4;

	//Read-only status, bit 0 relay busy
	localparam axi_addr_t REG_STATUS      = 8'h44;
	localparam int        STATUS_BUSY_BIT = 0;

endpackage

// File: hdl/crossbar_matrix.sv
`timescale 1ns/1ps

module crossbar_matrix
	import crossbar_pkg::*;
#(
	parameter trig_vec_t TRIG_INVERT = 12'h065
)(
	input  logic                 clk_250mhz,
	input  logic                 rst,
	input  trig_vec_t            trig_in,
	input  muxsel_t [N_TRIG-1:0] muxsel,
	output trig_vec_t            trig_out
);

	//Undo the board's swapped pairs
	trig_vec_t trig_fixed;
	assign trig_fixed = trig_in ^ TRIG_INVERT;

	//////////////////////////////////////////////////////////////////////
	// Two-flop synchronizer, inputs are asynchronous

	trig_vec_t sync_meta;
	trig_vec_t sync_q;

	always_ff @(posedge clk_250mhz) begin
		if (rst) begin
			sync_meta <= '0;
			sync_q    <= '0;
		end else begin
			sync_meta <= trig_fixed;
			sync_q    <= sync_meta;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output selection, registered, every output each cycle

	always_ff @(posedge clk_250mhz) begin
		if (rst)
			trig_out <= '0;
		else begin
			for (int k = 0; k < N_TRIG; k++) begin
				//Out of range selector means off
				if (muxsel[k] < N_TRIG)
					trig_out[k] <= sync_q[muxsel[k]];
				else
					trig_out[k] <= 1'b0;
			end
		end
	end

endmodule

// File: hdl/axil_regs.sv
`timescale 1ns/1ps

module axil_regs
	import crossbar_pkg::*;
	import axil_regmap_pkg::*;
(
	input  logic                 clk_250mhz,
	input  logic                 rst,

	//AXI4-Lite slave
	input  logic                 awvalid,
	output logic                 awready,
	input  axi_addr_t            awaddr,
	input  logic                 wvalid,
	output logic                 wready,
	input  axi_data_t            wdata,
	//Byte strobes not supported, full-word writes only
	input  axi_strb_t            wstrb,
	output logic                 bvalid,
	input  logic                 bready,
	output axi_resp_t            bresp,
	input  logic                 arvalid,
	output logic                 arready,
	input  axi_addr_t            araddr,
	output logic                 rvalid,
	input  logic                 rready,
	output axi_data_t            rdata,
	output axi_resp_t            rresp,

	//Relay controller
	input  logic                 relay_busy,
	output logic                 relay_start,
	output relay_chan_t          relay_chan,
	output logic                 relay_dir,

	//Crossbar selectors
	output muxsel_t [N_TRIG-1:0] muxsel
);

	//Byte address of one output's selector
	function automatic axi_addr_t sel_addr(input int k);
		return REG_MUXSEL_BASE + axi_addr_t'(k * 4);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Handshake enables

	//Low in reset, high from the first cycle after
	logic ready_en;

	always_ff @(posedge clk_250mhz) begin
		if (rst)
			ready_en <= 1'b0;
		else
			ready_en <= 1'b1;
	end

	logic      aw_held;
	logic      w_held;
	axi_addr_t aw_addr_q;
	axi_data_t w_data_q;
	logic      wr_fire;
	axi_resp_t wr_resp;

	//Nothing new accepted while a response is pending
	assign awready = ready_en && !aw_held && !bvalid;
	assign wready  = ready_en && !w_held && !bvalid;
	assign arready = ready_en && !rvalid;

	//////////////////////////////////////////////////////////////////////
	// Write path

	//Address and data captured independently
	always_ff @(posedge clk_250mhz) begin
		if (rst) begin
			aw_held <= 1'b0;
			w_held  <= 1'b0;
		end else begin
			if (awvalid && awready)
				aw_held <= 1'b1;
			else if (wr_fire)
				aw_held <= 1'b0;

			if (wvalid && wready)
				w_held <= 1'b1;
			else if (wr_fire)
				w_held <= 1'b0;
		end
	end

	always_ff @(posedge clk_250mhz) begin
		if (awvalid && awready)
			aw_addr_q <= awaddr;
		if (wvalid && wready)
			w_data_q <= wdata;
	end

	//Both halves present
	assign wr_fire = aw_held && w_held;

	//Writable targets, status and unmapped give SLVERR
	always_comb begin
		wr_resp = RESP_SLVERR;
		if (aw_addr_q == REG_RELAY_CMD)
			wr_resp = RESP_OKAY;
		for (int k = 0; k < N_TRIG; k++) begin
			if (aw_addr_q == sel_addr(k))
				wr_resp = RESP_OKAY;
		end
	end

	//Selectors, all outputs off out of reset
	always_ff @(posedge clk_250mhz) begin
		if (rst) begin
			for (int k = 0; k < N_TRIG; k++)
				muxsel[k] <= MUXSEL_OFF;
		end else if (wr_fire) begin
			for (int k = 0; k < N_TRIG; k++) begin
				if (aw_addr_q == sel_addr(k))
					muxsel[k] <= w_data_q[$bits(muxsel_t)-1:0];
			end
		end
	end

	//Relay command goes straight out on the write cycle
	assign relay_start = wr_fire && (aw_addr_q == REG_RELAY_CMD);
	assign relay_chan  = w_data_q[$bits(relay_chan_t)-1:0];
	assign relay_dir   = w_data_q[RELAY_DIR_BIT];

	//Single write response, held until bready
	always_ff @(posedge clk_250mhz) begin
		if (rst)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk_250mhz) begin
		if (wr_fire)
			bresp <= wr_resp;
	end

	//////////////////////////////////////////////////////////////////////
	// Read path

	axi_data_t rd_data;
	axi_resp_t rd_resp;

	//Decode on the incoming address
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_SLVERR;
		if (araddr == REG_RELAY_CMD)
			rd_resp = RESP_OKAY;
		if (araddr == REG_STATUS) begin
			rd_resp                  = RESP_OKAY;
			rd_data[STATUS_BUSY_BIT] = relay_busy;
		end
		for (int k = 0; k < N_TRIG; k++) begin
			if (araddr == sel_addr(k)) begin
				rd_resp                       = RESP_OKAY;
				rd_data[$bits(muxsel_t)-1:0]  = muxsel[k];
			end
		end
	end

	//One response in flight at a time
	always_ff @(posedge clk_250mhz) begin
		if (rst)
			rvalid <= 1'b0;
		else if (arvalid && arready)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk_250mhz) begin
		if (arvalid && arready) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

endmodule

// File: hdl/relay_controller.sv
`timescale 1ns/1ps

module relay_controller
	import crossbar_pkg::*;
#(
	//Coil pulse length in clocks
	parameter int RELAY_PULSE_CYCLES = 2500000
)(
	input  logic        clk_250mhz,
	input  logic        rst,

	//Move request
	input  logic        relay_start,
	input  relay_chan_t relay_chan,
	input  logic        relay_dir,
	output logic        relay_busy,

	//H-bridge sides, one relay bit each
	output relay_vec_t  relay_a,
	output relay_vec_t  relay_b
);

	localparam int CNT_W = $clog2(RELAY_PULSE_CYCLES + 1);

	typedef enum logic {
		IDLE,
		PULSE
	} state_t;

	state_t             state;
	logic [CNT_W-1:0]   count;
	relay_chan_t        chan_q;
	logic               dir_q;
	relay_vec_t         chan_onehot;

	//////////////////////////////////////////////////////////////////////
	// Pulse sequencer

	always_ff @(posedge clk_250mhz) begin
		if (rst) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				IDLE: begin
					//Commands only taken when idle
					if (relay_start) begin
						state <= PULSE;
						count <= CNT_W'(RELAY_PULSE_CYCLES - 1);
					end
				end

				PULSE: begin
					//Last cycle of the pulse at zero
					if (count == '0)
						state <= IDLE;
					else
						count <= count - 1'b1;
				end

				default: state <= IDLE;
			endcase
		end
	end

	//Latch target relay and side
	always_ff @(posedge clk_250mhz) begin
		if ((state == IDLE) && relay_start) begin
			chan_q <= relay_chan;
			dir_q  <= relay_dir;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bridge outputs

	assign chan_onehot = relay_vec_t'(1) << chan_q;
	assign relay_busy  = (state == PULSE);

	//Exactly one side of one relay at a time
	assign relay_a = (relay_busy && dir_q)  ? chan_onehot : '0;
	assign relay_b = (relay_busy && !dir_q) ? chan_onehot : '0;

endmodule

// File: hdl/trigger_crossbar.sv
`timescale 1ns/1ps

module trigger_crossbar
	import crossbar_pkg::*;
	import axil_regmap_pkg::*;
#(
	//Inputs with P/N swapped on the PCB
	parameter trig_vec_t TRIG_INVERT        = 12'h065,
	//10 ms coil pulse at 250 MHz
	parameter int        RELAY_PULSE_CYCLES = 2500000
)(
	input  logic       clk_250mhz,
	input  logic       rst,

	//Front panel triggers
	input  trig_vec_t  trig_in,
	output trig_vec_t  trig_out,

	//H-bridge drive
	output relay_vec_t relay_a,
	output relay_vec_t relay_b,

	//AXI4-Lite slave
	input  logic       awvalid,
	output logic       awready,
	input  axi_addr_t  awaddr,
	input  logic       wvalid,
	output logic       wready,
	input  axi_data_t  wdata,
	input  axi_strb_t  wstrb,
	output logic       bvalid,
	input  logic       bready,
	output axi_resp_t  bresp,
	input  logic       arvalid,
	output logic       arready,
	input  axi_addr_t  araddr,
	output logic       rvalid,
	input  logic       rready,
	output axi_data_t  rdata,
	output axi_resp_t  rresp
);

	//////////////////////////////////////////////////////////////////////
	// Register block

	muxsel_t [N_TRIG-1:0] muxsel;
	logic                 relay_start;
	relay_chan_t          relay_chan;
	logic                 relay_dir;
	logic                 relay_busy;

	axil_regs regs (.*);

	//////////////////////////////////////////////////////////////////////
	// Crossbar and relays

	crossbar_matrix #(
		.TRIG_INVERT(TRIG_INVERT)
	) matrix (.*);

	relay_controller #(
		.RELAY_PULSE_CYCLES(RELAY_PULSE_CYCLES)
	) relays (.*);

endmodule

// File: verif/tb_trigger_crossbar.sv
`timescale 1ns/1ps

module tb_trigger_crossbar
	import crossbar_pkg::*;
	import axil_regmap_pkg::*;
;

	//Board swapped-pair mask
	localparam trig_vec_t BOARD_INVERT = 12'h065;
	localparam int        PULSE_LEN    = 20;
	localparam int        HS_TIMEOUT   = 50;

	logic       clk_250mhz;
	logic       rst;
	trig_vec_t  trig_in;
	trig_vec_t  trig_out;
	relay_vec_t relay_a;
	relay_vec_t relay_b;
	logic       awvalid;
	logic       awready;
	axi_addr_t  awaddr;
	logic       wvalid;
	logic       wready;
	axi_data_t  wdata;
	axi_strb_t  wstrb;
	logic       bvalid;
	logic       bready;
	axi_resp_t  bresp;
	logic       arvalid;
	logic       arready;
	axi_addr_t  araddr;
	logic       rvalid;
	logic       rready;
	axi_data_t  rdata;
	axi_resp_t  rresp;

	int          value_errs   = 0;
	int          timeout_errs = 0;
	logic [15:0] lfsr_state   = 16'd93;
	//Reference copy of the selectors
	muxsel_t     model_sel [N_TRIG];

	trigger_crossbar #(
		.RELAY_PULSE_CYCLES(PULSE_LEN)
	) trigger_crossbar_i (.*);

	initial begin
		clk_250mhz = 1'b0;
		forever #4 clk_250mhz = ~clk_250mhz;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	//Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb        = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ 16'hB400;
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	//Expected outputs for one input vector
	function automatic trig_vec_t predict_out(input trig_vec_t x);
		trig_vec_t fixed;
		trig_vec_t y;
		fixed = x ^ BOARD_INVERT;
		y     = '0;
		for (int k = 0; k < N_TRIG; k++) begin
			if (model_sel[k] < 12)
				y[k] = fixed[model_sel[k]];
		end
		return y;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
		value_errs++;
	endtask

	task automatic note_timeout(input string what);
		$display("Timeout: DUT never completed the %s", what);
		timeout_errs++;
	endtask

	//Starts on a falling edge and returns on the one that shows bvalid
	task automatic write_reg(input axi_addr_t addr, input axi_data_t data,
			output axi_resp_t resp);
		int   waited;
		logic aw_go;
		logic w_go;
		resp    = 'x;
		awaddr  = addr;
		wdata   = data;
		wstrb   = '1;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		waited  = 0;
		while (awvalid || wvalid) begin
			aw_go = awvalid && awready;
			w_go  = wvalid && wready;
			@(negedge clk_250mhz);
			if (aw_go)
				awvalid = 1'b0;
			if (w_go)
				wvalid = 1'b0;
			waited++;
			if (waited > HS_TIMEOUT) begin
				note_timeout("write address or data handshake");
				awvalid = 1'b0;
				wvalid  = 1'b0;
			end
		end
		waited = 0;
		while (!bvalid && waited <= HS_TIMEOUT) begin
			@(negedge clk_250mhz);
			waited++;
		end
		if (!bvalid)
			note_timeout("write response");
		else
			resp = bresp;
	endtask

	task automatic read_reg(input axi_addr_t addr, output axi_data_t data,
			output axi_resp_t resp);
		int   waited;
		logic ar_go;
		data    = 'x;
		resp    = 'x;
		araddr  = addr;
		arvalid = 1'b1;
		waited  = 0;
		while (arvalid) begin
			ar_go = arready;
			@(negedge clk_250mhz);
			if (ar_go)
				arvalid = 1'b0;
			waited++;
			if (waited > HS_TIMEOUT) begin
				note_timeout("read address handshake");
				arvalid = 1'b0;
			end
		end
		waited = 0;
		while (!rvalid && waited <= HS_TIMEOUT) begin
			@(negedge clk_250mhz);
			waited++;
		end
		if (!rvalid)
			note_timeout("read response");
		else begin
			data = rdata;
			resp = rresp;
		end
	endtask

	//Counts pulse cycles until both bridge sides drop
	task automatic follow_pulse(input string name, input relay_vec_t exp_a,
			input relay_vec_t exp_b, output int high);
		high = 0;
		while ((relay_a | relay_b) != '0 && high <= PULSE_LEN + HS_TIMEOUT) begin
			if (relay_a !== exp_a || relay_b !== exp_b)
				report_mismatch(name, {exp_a, exp_b}, {relay_a, relay_b});
			high++;
			@(negedge clk_250mhz);
		end
		if (high > PULSE_LEN + HS_TIMEOUT)
			note_timeout("relay pulse");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		axi_resp_t   resp;
		axi_data_t   data;
		trig_vec_t   hist [3];
		trig_vec_t   exp_out;
		relay_vec_t  exp_vec;
		relay_chan_t chan;
		logic        dir;
		int          high;

		rst     = 1'b1;
		trig_in = '0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b1;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b1;
		repeat (10) @(posedge clk_250mhz);
		@(negedge clk_250mhz);
		rst = 1'b0;

		//Reset state
		if (trig_out !== '0)
			report_mismatch("reset trig_out", 0, trig_out);
		if ((relay_a | relay_b) !== '0)
			report_mismatch("reset relays", 0, {relay_a, relay_b});
		for (int k = 0; k < N_TRIG; k++) begin
			read_reg(REG_MUXSEL_BASE + axi_addr_t'(4 * k), data, resp);
			if (data !== 32'd15 || resp !== RESP_OKAY)
				report_mismatch("reset selector", {28'd15, RESP_OKAY}, {data[27:0], resp});
		end

		//Random routing including off selectors
		for (int k = 0; k < N_TRIG; k++) begin
			model_sel[k] = rand_bits(4);
			write_reg(REG_MUXSEL_BASE + axi_addr_t'(4 * k), model_sel[k], resp);
			if (resp !== RESP_OKAY)
				report_mismatch("selector write resp", RESP_OKAY, resp);
		end
		hist[0] = trig_in;
		hist[1] = trig_in;
		hist[2] = trig_in;
		@(negedge clk_250mhz);
		for (int i = 0; i < 200; i++) begin
			exp_out = predict_out(hist[2]);
			if (trig_out !== exp_out)
				report_mismatch("routing", exp_out, trig_out);
			hist[2] = hist[1];
			hist[1] = hist[0];
			hist[0] = rand_bits(N_TRIG);
			trig_in = hist[0];
			@(negedge clk_250mhz);
		end

		//Readback and error responses
		for (int k = 0; k < N_TRIG; k++) begin
			read_reg(REG_MUXSEL_BASE + axi_addr_t'(4 * k), data, resp);
			if (data !== axi_data_t'(model_sel[k]) || resp !== RESP_OKAY)
				report_mismatch("selector readback", {model_sel[k], RESP_OKAY},
					{data[3:0], resp});
		end
		read_reg(8'h80, data, resp);
		if (data !== '0 || resp !== RESP_SLVERR)
			report_mismatch("unmapped read", {28'd0, RESP_SLVERR}, {data[27:0], resp});
		write_reg(REG_STATUS, 32'h1, resp);
		if (resp !== RESP_SLVERR)
			report_mismatch("status write resp", RESP_SLVERR, resp);

		//Single relay pulse
		repeat (2) @(negedge clk_250mhz);
		chan          = rand_bits(2);
		dir           = rand_bits(1);
		exp_vec       = '0;
		exp_vec[chan] = 1'b1;
		write_reg(REG_RELAY_CMD, (axi_data_t'(dir) << 4) | axi_data_t'(chan), resp);
		if (resp !== RESP_OKAY)
			report_mismatch("relay cmd resp", RESP_OKAY, resp);
		follow_pulse("relay pulse", dir ? exp_vec : '0, dir ? '0 : exp_vec, high);
		if (high != PULSE_LEN)
			report_mismatch("relay pulse length", PULSE_LEN, high);

		//Busy status and a command during the pulse
		chan          = rand_bits(2);
		dir           = rand_bits(1);
		exp_vec       = '0;
		exp_vec[chan] = 1'b1;
		write_reg(REG_RELAY_CMD, (axi_data_t'(dir) << 4) | axi_data_t'(chan), resp);
		read_reg(REG_STATUS, data, resp);
		if (data !== 32'h1 || resp !== RESP_OKAY)
			report_mismatch("status busy", {28'd1, RESP_OKAY}, {data[27:0], resp});
		//Other channel and other side
		write_reg(REG_RELAY_CMD, (axi_data_t'(!dir) << 4) | axi_data_t'(chan + 2'd1), resp);
		if (resp !== RESP_OKAY)
			report_mismatch("busy cmd resp", RESP_OKAY, resp);
		follow_pulse("relay during busy", dir ? exp_vec : '0, dir ? '0 : exp_vec, high);
		read_reg(REG_STATUS, data, resp);
		if (data !== '0 || resp !== RESP_OKAY)
			report_mismatch("status idle", {28'd0, RESP_OKAY}, {data[27:0], resp});
		repeat (5) begin
			@(negedge clk_250mhz);
			if ((relay_a | relay_b) !== '0)
				report_mismatch("ignored cmd", 0, {relay_a, relay_b});
		end

		$display("Errors: %0d mismatches, %0d timeouts", value_errs, timeout_errs);
		if (value_errs == 0 && timeout_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: tb.f
hdl/crossbar_pkg.sv
hdl/axil_regmap_pkg.sv
hdl/crossbar_matrix.sv
hdl/axil_regs.sv
hdl/relay_controller.sv
hdl/trigger_crossbar.sv
verif/tb_trigger_crossbar.sv

// File: Bender.yml
package:
  name: trigger_crossbar

sources:
  - files:
      - hdl/crossbar_pkg.sv
      - hdl/axil_regmap_pkg.sv
      - hdl/crossbar_matrix.sv
      - hdl/axil_regs.sv
      - hdl/relay_controller.sv
      - hdl/trigger_crossbar.sv
  - target: test
    files:
      - verif/tb_trigger_crossbar.sv
